//--- verilog/blob_pkg.sv
`default_nettype none

package blob_pkg;

    localparam int LABEL_W = 6;  // label 0 is background
    localparam int AREA_W  = 16;

    typedef logic [LABEL_W-1:0] label_t;
    typedef logic [AREA_W-1:0]  area_t;

    // keep is the smaller root, drop the larger one
    typedef struct packed {
        logic   valid;
        label_t keep;
        label_t drop;
    } merge_req_t;

    typedef enum logic [1:0] {
        tbl_collect,
        tbl_resolve,
        tbl_ready
    } table_phase_e;

    typedef enum logic [2:0] {
        cen_idle,
        cen_findmax,
        cen_count,
        cen_report
    } census_state_e;

    typedef enum logic {
        scan_run,
        scan_wait
    } scan_state_e;

endpackage

`default_nettype wire

//--- verilog/pixel_credit_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module pixel_credit_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire  i_clk,
    input  wire  i_rst_n,
    input  wire  i_pix_valid,
    input  wire  i_pix,
    input  wire  i_pop,
    output logic o_credit,
    output logic o_head_valid,
    output logic o_head_pix
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic             mem_q [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             wr_en;
    logic             rd_en;

    assign wr_en        = i_pix_valid && (count_q != CNT_W'(FIFO_DEPTH));
    assign rd_en        = i_pop && (count_q != '0);
    assign o_head_valid = (count_q != '0);
    assign o_head_pix   = mem_q[rd_ptr_q];
    assign o_credit     = rd_en;  // one credit back per popped beat

    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            mem_q[wr_ptr_q] <= i_pix;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (rd_en) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (wr_en && !rd_en) begin
                count_q <= count_q + 1'b1;
            end else if (rd_en && !wr_en) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/label_scan.sv
`timescale 1ns/1ns
`default_nettype none

module label_scan #(
    parameter int IMG_COLS = 16,
    parameter int IMG_ROWS = 8
) (
    input  wire                   i_clk,
    input  wire                   i_rst_n,
    input  wire                   i_head_valid,
    input  wire                   i_head_pix,
    input  wire blob_pkg::label_t i_root_a,
    input  wire blob_pkg::label_t i_root_b,
    input  wire                   i_tbl_idle,
    output logic                  o_pop,
    output blob_pkg::label_t      o_lkp_a,
    output blob_pkg::label_t      o_lkp_b,
    output logic                  o_inc_valid,
    output blob_pkg::label_t      o_inc_label,
    output logic                  o_new_valid,
    output blob_pkg::label_t      o_new_label,
    output blob_pkg::merge_req_t  o_merge,
    output logic                  o_frame_done
);

    localparam int COL_W = (IMG_COLS > 1) ? $clog2(IMG_COLS) : 1;
    localparam int ROW_W = (IMG_ROWS > 1) ? $clog2(IMG_ROWS) : 1;

    blob_pkg::scan_state_e state_q;
    blob_pkg::label_t      line_buf_q [IMG_COLS];  // labels of the previous row
    blob_pkg::label_t      left_q;
    blob_pkg::label_t      next_lbl_q;              // wraps to 0 once labels run out
    logic [COL_W-1:0]      col_q;
    logic [ROW_W-1:0]      row_q;
    logic                  idle_q;
    logic                  frame_release;
    logic                  last_col;
    logic                  last_pix;
    blob_pkg::label_t      root_up;
    blob_pkg::label_t      root_left;
    blob_pkg::label_t      assigned;
    logic                  is_new;
    blob_pkg::merge_req_t  merge_d;

    assign o_pop         = (state_q == blob_pkg::scan_run) && i_head_valid;
    assign o_lkp_a       = (row_q == '0) ? '0 : line_buf_q[col_q];
    assign o_lkp_b       = (col_q == '0) ? '0 : left_q;
    assign last_col      = (col_q == COL_W'(IMG_COLS - 1));
    assign last_pix      = last_col && (row_q == ROW_W'(IMG_ROWS - 1));
    assign frame_release = (state_q == blob_pkg::scan_wait) && i_tbl_idle && !idle_q;

    // the table has not applied last pixel's events yet, so forward them here
    always_comb begin
        root_up   = i_root_a;
        root_left = i_root_b;
        if (o_merge.valid && root_up == o_merge.drop) begin
            root_up = o_merge.keep;
        end
        if (o_new_valid && o_lkp_a == o_new_label) begin
            root_up = o_new_label;
        end
        if (o_new_valid && o_lkp_b == o_new_label) begin
            root_left = o_new_label;
        end
    end

    always_comb begin
        assigned      = '0;
        is_new        = 1'b0;
        merge_d       = '0;
        if (i_head_pix) begin
            if (root_up == '0 && root_left == '0) begin
                if (next_lbl_q != '0) begin
                    assigned = next_lbl_q;
                    is_new   = 1'b1;
                end
            end else if (root_up == '0) begin
                assigned = root_left;
            end else if (root_left == '0) begin
                assigned = root_up;
            end else begin
                assigned      = (root_up < root_left) ? root_up : root_left;
                merge_d.valid = (root_up != root_left);
                merge_d.keep  = assigned;
                merge_d.drop  = (root_up < root_left) ? root_left : root_up;
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q      <= blob_pkg::scan_run;
            col_q        <= '0;
            row_q        <= '0;
            next_lbl_q   <= blob_pkg::label_t'(1);
            idle_q       <= 1'b1;
            o_inc_valid  <= 1'b0;
            o_new_valid  <= 1'b0;
            o_merge      <= '0;
            o_frame_done <= 1'b0;
        end else begin
            idle_q       <= i_tbl_idle;
            o_inc_valid  <= o_pop && (assigned != '0) && !is_new;
            o_new_valid  <= o_pop && is_new;
            o_merge      <= o_pop ? merge_d : '0;
            o_frame_done <= o_pop && last_pix;
            if (o_pop) begin
                if (is_new) begin
                    next_lbl_q <= next_lbl_q + 1'b1;
                end
                if (last_pix) begin
                    col_q   <= '0;
                    row_q   <= '0;
                    state_q <= blob_pkg::scan_wait;  // hold input until census is done
                end else if (last_col) begin
                    col_q <= '0;
                    row_q <= row_q + 1'b1;
                end else begin
                    col_q <= col_q + 1'b1;
                end
            end
            if (frame_release) begin
                state_q    <= blob_pkg::scan_run;
                next_lbl_q <= blob_pkg::label_t'(1);
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (frame_release) begin
            for (int i = 0; i < IMG_COLS; i++) begin
                line_buf_q[i] <= '0;
            end
        end else if (o_pop) begin
            line_buf_q[col_q] <= assigned;
            left_q            <= assigned;
        end
        if (o_pop) begin
            o_inc_label <= assigned;
            o_new_label <= assigned;
        end
    end

endmodule

`default_nettype wire

//--- verilog/label_table.sv
`timescale 1ns/1ns
`default_nettype none

module label_table (
    input  wire                       i_clk,
    input  wire                       i_rst_n,
    input  wire                       i_inc_valid,
    input  wire blob_pkg::label_t     i_inc_label,
    input  wire                       i_new_valid,
    input  wire blob_pkg::label_t     i_new_label,
    input  wire blob_pkg::merge_req_t i_merge,
    input  wire blob_pkg::label_t     i_lkp_a,
    input  wire blob_pkg::label_t     i_lkp_b,
    input  wire                       i_frame_done,
    input  wire blob_pkg::label_t     i_rd_label,
    input  wire                       i_census_done,
    output blob_pkg::label_t          o_root_a,
    output blob_pkg::label_t          o_root_b,
    output blob_pkg::area_t           o_rd_area,
    output logic                      o_resolved,
    output logic                      o_tbl_idle
);

    localparam int N_LBL = 2 ** blob_pkg::LABEL_W;

    blob_pkg::table_phase_e phase_q;
    blob_pkg::label_t       parent_q [N_LBL];  // always holds a root, table is flat
    blob_pkg::area_t        area_q   [N_LBL];
    blob_pkg::label_t       res_idx_q;
    blob_pkg::label_t       res_parent;

    assign o_root_a   = parent_q[i_lkp_a];
    assign o_root_b   = parent_q[i_lkp_b];
    assign o_rd_area  = area_q[i_rd_label];
    assign o_tbl_idle = (phase_q == blob_pkg::tbl_collect);
    assign res_parent = parent_q[res_idx_q];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            phase_q    <= blob_pkg::tbl_collect;
            res_idx_q  <= '0;
            o_resolved <= 1'b0;
            for (int i = 0; i < N_LBL; i++) begin
                parent_q[i] <= '0;
                area_q[i]   <= '0;
            end
        end else begin
            o_resolved <= 1'b0;
            case (phase_q)
                blob_pkg::tbl_collect: begin
                    if (i_merge.valid) begin
                        for (int i = 0; i < N_LBL; i++) begin
                            if (parent_q[i] == i_merge.drop) begin
                                parent_q[i] <= i_merge.keep;
                            end
                        end
                    end
                    if (i_new_valid) begin
                        parent_q[i_new_label] <= i_new_label;
                        area_q[i_new_label]   <= blob_pkg::area_t'(1);
                    end
                    if (i_inc_valid) begin
                        area_q[i_inc_label] <= area_q[i_inc_label] + 1'b1;
                    end
                    if (i_frame_done) begin
                        phase_q   <= blob_pkg::tbl_resolve;
                        res_idx_q <= '1;  // start from the top label
                    end
                end
                blob_pkg::tbl_resolve: begin
                    // parent is always smaller, so it is visited later and stays put
                    if (res_parent != res_idx_q && res_parent != '0) begin
                        area_q[res_parent] <= area_q[res_parent] + area_q[res_idx_q];
                        area_q[res_idx_q]  <= '0;
                    end
                    res_idx_q <= res_idx_q - 1'b1;
                    if (res_idx_q == blob_pkg::label_t'(1)) begin
                        phase_q    <= blob_pkg::tbl_ready;
                        o_resolved <= 1'b1;
                    end
                end
                blob_pkg::tbl_ready: begin
                    if (i_census_done) begin
                        phase_q <= blob_pkg::tbl_collect;
                        for (int i = 0; i < N_LBL; i++) begin
                            parent_q[i] <= '0;
                            area_q[i]   <= '0;
                        end
                    end
                end
                default: phase_q <= blob_pkg::tbl_collect;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/blob_census.sv
`timescale 1ns/1ns
`default_nettype none

module blob_census (
    input  wire                   i_clk,
    input  wire                   i_rst_n,
    input  wire                   i_resolved,
    input  wire blob_pkg::area_t  i_rd_area,
    output blob_pkg::label_t      o_rd_label,
    output logic                  o_census_done,
    output logic                  o_result_valid,
    output blob_pkg::label_t      o_blob_count
);

    blob_pkg::census_state_e state_q;
    blob_pkg::label_t        idx_q;
    blob_pkg::area_t         max_q;
    blob_pkg::label_t        cnt_q;
    logic                    hit;
    logic                    last_idx;

    assign o_rd_label     = idx_q;
    assign hit            = (i_rd_area > (max_q >> 3));  // strictly above an eighth
    assign last_idx       = (idx_q == '1);
    assign o_result_valid = (state_q == blob_pkg::cen_report);
    assign o_census_done  = (state_q == blob_pkg::cen_report);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q      <= blob_pkg::cen_idle;
            idx_q        <= '0;
            max_q        <= '0;
            cnt_q        <= '0;
            o_blob_count <= '0;
        end else begin
            case (state_q)
                blob_pkg::cen_idle: begin
                    if (i_resolved) begin
                        state_q <= blob_pkg::cen_findmax;
                        idx_q   <= '0;
                        max_q   <= '0;
                        cnt_q   <= '0;
                    end
                end
                blob_pkg::cen_findmax: begin
                    if (i_rd_area > max_q) begin
                        max_q <= i_rd_area;
                    end
                    idx_q <= idx_q + 1'b1;  // wraps back to 0 for the count sweep
                    if (last_idx) begin
                        state_q <= blob_pkg::cen_count;
                    end
                end
                blob_pkg::cen_count: begin
                    cnt_q <= cnt_q + blob_pkg::label_t'(hit);
                    idx_q <= idx_q + 1'b1;
                    if (last_idx) begin
                        o_blob_count <= cnt_q + blob_pkg::label_t'(hit);
                        state_q      <= blob_pkg::cen_report;
                    end
                end
                blob_pkg::cen_report: state_q <= blob_pkg::cen_idle;
                default:              state_q <= blob_pkg::cen_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/blob_counter_top.sv
`timescale 1ns/1ns
`default_nettype none

module blob_counter_top #(
    parameter int IMG_COLS   = 16,
    parameter int IMG_ROWS   = 8,
    parameter int FIFO_DEPTH = 4   // also the credit count
) (
    input  wire              i_clk,
    input  wire              i_rst_n,
    input  wire              i_pix_valid,
    input  wire              i_pix,
    output logic             o_credit,
    output logic             o_result_valid,
    output blob_pkg::label_t o_blob_count
);

    logic                 head_valid;
    logic                 head_pix;
    logic                 pop;
    blob_pkg::label_t     lkp_a;
    blob_pkg::label_t     lkp_b;
    blob_pkg::label_t     root_a;
    blob_pkg::label_t     root_b;
    logic                 inc_valid;
    blob_pkg::label_t     inc_label;
    logic                 new_valid;
    blob_pkg::label_t     new_label;
    blob_pkg::merge_req_t merge;
    logic                 frame_done;
    logic                 tbl_idle;
    logic                 resolved;
    blob_pkg::label_t     rd_label;
    blob_pkg::area_t      rd_area;
    logic                 census_done;

    pixel_credit_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_pix_valid  (i_pix_valid),
        .i_pix        (i_pix),
        .i_pop        (pop),
        .o_credit     (o_credit),
        .o_head_valid (head_valid),
        .o_head_pix   (head_pix)
    );

    label_scan #(
        .IMG_COLS (IMG_COLS),
        .IMG_ROWS (IMG_ROWS)
    ) u_scan (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_head_valid (head_valid),
        .i_head_pix   (head_pix),
        .i_root_a     (root_a),
        .i_root_b     (root_b),
        .i_tbl_idle   (tbl_idle),
        .o_pop        (pop),
        .o_lkp_a      (lkp_a),
        .o_lkp_b      (lkp_b),
        .o_inc_valid  (inc_valid),
        .o_inc_label  (inc_label),
        .o_new_valid  (new_valid),
        .o_new_label  (new_label),
        .o_merge      (merge),
        .o_frame_done (frame_done)
    );

    label_table u_table (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_inc_valid   (inc_valid),
        .i_inc_label   (inc_label),
        .i_new_valid   (new_valid),
        .i_new_label   (new_label),
        .i_merge       (merge),
        .i_lkp_a       (lkp_a),
        .i_lkp_b       (lkp_b),
        .i_frame_done  (frame_done),
        .i_rd_label    (rd_label),
        .i_census_done (census_done),
        .o_root_a      (root_a),
        .o_root_b      (root_b),
        .o_rd_area     (rd_area),
        .o_resolved    (resolved),
        .o_tbl_idle    (tbl_idle)
    );

    blob_census u_census (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_resolved     (resolved),
        .i_rd_area      (rd_area),
        .o_rd_label     (rd_label),
        .o_census_done  (census_done),
        .o_result_valid (o_result_valid),
        .o_blob_count   (o_blob_count)
    );

endmodule

`default_nettype wire

//--- sim/tb_blob_counter.sv
`timescale 1ns/1ns
`default_nettype none

module tb_blob_counter;

    localparam int COLS           = 16;
    localparam int ROWS           = 8;
    localparam int FIFO_DEPTH     = 4;
    localparam int NPIX           = COLS * ROWS;
    localparam int NUM_DIRECTED   = 7;
    localparam int NUM_FRAMES     = NUM_DIRECTED + 20;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * (NPIX + 200 + 50) * 2;

    logic             i_clk = 1'b0;
    logic             i_rst_n = 1'b0;
    logic             i_pix_valid = 1'b0;
    logic             i_pix = 1'b0;
    logic             credit;
    logic             result_valid;
    blob_pkg::label_t blob_count;

    logic   frame_mem [NUM_FRAMES][NPIX];
    string  names [NUM_FRAMES];
    int     exp_q [$];  // expected count per frame, in send order
    int     exp_val;
    int     credits = FIFO_DEPTH;
    int     result_cnt = 0;
    int     pass_cnt = 0;
    int     fail_cnt = 0;
    integer seed = 32'h77fc_bb17;

    blob_counter_top #(
        .IMG_COLS   (COLS),
        .IMG_ROWS   (ROWS),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_dut (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_pix_valid    (i_pix_valid),
        .i_pix          (i_pix),
        .o_credit       (credit),
        .o_result_valid (result_valid),
        .o_blob_count   (blob_count)
    );

    always #2 i_clk = ~i_clk;

    // index of a 4-neighbour, -1 when it falls off the image
    function automatic int neighbour(input int q, input int d);
        int r;
        int c;
        r = q / COLS;
        c = q % COLS;
        case (d)
            0: return (c > 0) ? q - 1 : -1;
            1: return (c < COLS - 1) ? q + 1 : -1;
            2: return (r > 0) ? q - COLS : -1;
            default: return (r < ROWS - 1) ? q + COLS : -1;
        endcase
    endfunction

    // flood fill labelling, then count blobs above an eighth of the largest
    function automatic int reference_count(input int f);
        int lbl [NPIX];
        int area [NPIX + 1];
        int stack [NPIX];
        int sp;
        int nblob;
        int q;
        int n;
        int maxa;
        int cnt;
        nblob = 0;
        for (int p = 0; p < NPIX; p++) begin
            lbl[p] = 0;
        end
        for (int p = 0; p < NPIX; p++) begin
            if (frame_mem[f][p] && lbl[p] == 0) begin
                nblob++;
                area[nblob] = 0;
                lbl[p] = nblob;
                stack[0] = p;
                sp = 1;
                while (sp > 0) begin
                    sp--;
                    q = stack[sp];
                    area[nblob]++;
                    for (int d = 0; d < 4; d++) begin
                        n = neighbour(q, d);
                        if (n >= 0 && frame_mem[f][n] && lbl[n] == 0) begin
                            lbl[n] = nblob;  // mark on push so each pixel is stacked once
                            stack[sp] = n;
                            sp++;
                        end
                    end
                end
            end
        end
        maxa = 0;
        for (int b = 1; b <= nblob; b++) begin
            if (area[b] > maxa) begin
                maxa = area[b];
            end
        end
        cnt = 0;
        for (int b = 1; b <= nblob; b++) begin
            if (area[b] > (maxa >> 3)) begin
                cnt++;
            end
        end
        return cnt;
    endfunction

    // pixels that see no foreground on their left or above
    function automatic int new_labels(input int f);
        int n;
        bit left_fg;
        bit up_fg;
        n = 0;
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                left_fg = (c > 0) && frame_mem[f][r * COLS + c - 1];
                up_fg   = (r > 0) && frame_mem[f][(r - 1) * COLS + c];
                if (frame_mem[f][r * COLS + c] && !left_fg && !up_fg) begin
                    n++;
                end
            end
        end
        return n;
    endfunction

    task automatic clear_frame(input int f);
        for (int p = 0; p < NPIX; p++) begin
            frame_mem[f][p] = 1'b0;
        end
    endtask

    task automatic fill_rect(input int f, input int r0, input int r1, input int c0, input int c1);
        for (int r = r0; r <= r1; r++) begin
            for (int c = c0; c <= c1; c++) begin
                frame_mem[f][r * COLS + c] = 1'b1;
            end
        end
    endtask

    task automatic build_frames();
        for (int f = 0; f < NUM_DIRECTED; f++) begin
            clear_frame(f);
        end
        names[0] = "empty frame";
        names[1] = "full frame";
        fill_rect(1, 0, ROWS - 1, 0, COLS - 1);
        names[2] = "equal squares";
        fill_rect(2, 1, 2, 1, 2);
        fill_rect(2, 1, 2, 6, 7);
        fill_rect(2, 5, 6, 1, 2);
        fill_rect(2, 5, 6, 10, 11);
        names[3] = "eighth threshold";
        fill_rect(3, 0, 1, 0, 7);  // area 16, so the bar is 2
        fill_rect(3, 4, 4, 0, 1);
        fill_rect(3, 6, 6, 0, 2);
        names[4] = "u shape";
        fill_rect(4, 0, 5, 2, 2);
        fill_rect(4, 0, 5, 6, 6);
        fill_rect(4, 6, 6, 2, 6);
        names[5] = "comb";
        fill_rect(5, 0, 0, 0, 1);
        for (int c = 0; c < COLS; c += 2) begin
            fill_rect(5, 3, 6, c, c);
        end
        fill_rect(5, 7, 7, 0, COLS - 1);
        names[6] = "merge chain";
        fill_rect(6, 0, 4, 5, 5);
        fill_rect(6, 0, 4, 10, 10);
        fill_rect(6, 0, 2, 14, 14);
        fill_rect(6, 2, 2, 10, 14);  // 3 folds into 2 first
        fill_rect(6, 4, 4, 5, 10);   // then 2 folds into 1
        for (int f = NUM_DIRECTED; f < NUM_FRAMES; f++) begin
            names[f] = $sformatf("random %0d", f - NUM_DIRECTED);
            do begin
                for (int p = 0; p < NPIX; p++) begin
                    frame_mem[f][p] = ($unsigned($random(seed)) % 100) < 30;
                end
            end while (new_labels(f) > 63);
        end
        for (int f = 0; f < NUM_FRAMES; f++) begin
            exp_q.push_back(reference_count(f));
        end
    endtask

    task automatic send_frame(input int f, input bit gaps);
        int k;
        k = 0;
        while (k < NPIX) begin
            @(posedge i_clk);
            #1;
            i_pix_valid = 1'b0;
            if (credits > 0 && !(gaps && ($unsigned($random(seed)) % 4) == 0)) begin
                i_pix_valid = 1'b1;
                i_pix       = frame_mem[f][k];
                k++;
            end
        end
    endtask

    // credit bookkeeping mid-cycle, where both pop and beat are settled
    always @(negedge i_clk) begin
        if (i_rst_n) begin
            credits = credits + (credit ? 1 : 0) - (i_pix_valid ? 1 : 0);
            assert (credits >= 0 && credits <= FIFO_DEPTH) else begin
                fail_cnt++;
                $display("source credit count %0d left the range 0 to %0d at %0t ns",
                         credits, FIFO_DEPTH, $time);
            end
        end
    end

    always @(negedge i_clk) begin
        if (i_rst_n && result_valid) begin
            if (exp_q.size() == 0) begin
                fail_cnt++;
                $display("a result arrived at %0t ns with no frame outstanding", $time);
            end else begin
                exp_val = exp_q.pop_front();
                assert (blob_count == blob_pkg::label_t'(exp_val)) begin
                    pass_cnt++;
                    $display("test %0d (%s): pass, %0d blobs", result_cnt,
                             names[result_cnt], exp_val);
                end else begin
                    fail_cnt++;
                    $display("[FAIL] %0t ns: test %0d (%s) expected %0d blobs, got %0d",
                             $time, result_cnt, names[result_cnt], exp_val, blob_count);
                end
                result_cnt++;
            end
        end
    end

    initial begin : watchdog
        int cyc;
        cyc = 0;
        while (cyc < TIMEOUT_CYCLES) begin
            @(posedge i_clk);
            cyc++;
        end
        $display("run did not finish within %0d cycles, %0d of %0d results seen",
                 TIMEOUT_CYCLES, result_cnt, NUM_FRAMES);
        $display("Verification failed");
        $finish;
    end

    initial begin
        build_frames();
        repeat (10) @(posedge i_clk);
        #1;
        i_rst_n = 1'b1;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            send_frame(f, f >= NUM_DIRECTED);  // frames go back to back
        end
        @(posedge i_clk);
        #1;
        i_pix_valid = 1'b0;
        wait (result_cnt == NUM_FRAMES);
        repeat (4) @(posedge i_clk);
        $display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && pass_cnt == NUM_FRAMES) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
verilog/blob_pkg.sv
verilog/pixel_credit_fifo.sv
verilog/label_scan.sv
verilog/label_table.sv
verilog/blob_census.sv
verilog/blob_counter_top.sv
sim/tb_blob_counter.sv
